/* include/muldiv_params.svh */
// register map, command encoding and widths of the multiply/divide coprocessor
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

`define MULDIV_WIDTH     32
`define MULDIV_ADR_WIDTH 3

// word addresses on the wishbone port
`define REG_OPA    3'd0
`define REG_OPB    3'd1
`define REG_CMD    3'd2
`define REG_STATUS 3'd3
`define REG_HI     3'd4
`define REG_LO     3'd5

// bit positions in the command word
`define CMD_MUL_BIT    0
`define CMD_DIV_BIT    1
`define CMD_SIGNED_BIT 2
`define CMD_ADD_BIT    3
`define CMD_SUB_BIT    4
`define CMD_ABORT_BIT  5

`endif

/* hdl/muldiv_pkg.sv */
// shared data types and engine state encoding of the multiply/divide coprocessor
`default_nettype none

`include "muldiv_params.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_WIDTH-1:0] word_t;

    typedef logic [`MULDIV_ADR_WIDTH-1:0] reg_adr_t;

    // one count per iteration step, wraps after the last one
    typedef logic [$clog2(`MULDIV_WIDTH)-1:0] tick_t;

    typedef enum logic [3:0] {
        WAIT,
        MAKE_ABS_A,
        MAKE_ABS_B,
        MUL,
        DIV,
        NEG_PRODUCT_TLO,
        NEG_PRODUCT_THI,
        NEG_QUOTIENT_TLO,
        NEG_REMAINDER_THI,
        SUB_TLO,
        SUB_THI,
        ADD_TLO,
        ADD_THI,
        STORAGE
    } engine_state_t;

endpackage

`default_nettype wire

/* hdl/muldiv_core.sv */
// iterative multiply/divide engine around one shared adder, with sign and accumulate fix-ups
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,
    input  logic              mul,
    input  logic              div,
    input  logic              using_sign,
    input  logic              add,
    input  logic              sub,
    input  muldiv_pkg::word_t a,
    input  muldiv_pkg::word_t b,
    input  muldiv_pkg::word_t hi_in,
    input  muldiv_pkg::word_t lo_in,
    output muldiv_pkg::word_t hi_out,
    output muldiv_pkg::word_t lo_out,
    output logic              write_hi_lo
);

    localparam int N = `MULDIV_WIDTH;

    typedef enum logic [2:0] {THI_HOLD, THI_ALU, THI_MUL, THI_DIV, THI_ZERO} thi_sel_t;
    typedef enum logic [1:0] {TLO_HOLD, TLO_ALU, TLO_MUL, TLO_DIV} tlo_sel_t;
    typedef enum logic [2:0] {SRCA_ZERO, SRCA_THI, SRCA_THI_SHIFT, SRCA_HI, SRCA_LO} src_a_sel_t;
    typedef enum logic [2:0] {
        SRCB_THI, SRCB_TLO, SRCB_A, SRCB_B, SRCB_ABS_B, SRCB_AITER_B
    } src_b_sel_t;
    typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_COUT} cin_sel_t;

    muldiv_pkg::engine_state_t state, next_state, op_state, acc_state;
    muldiv_pkg::tick_t tick_count;
    muldiv_pkg::word_t a_neg, b_neg, a_abs, b_abs;
    // temporary hi/lo holding the partial result
    muldiv_pkg::word_t thi, tlo;
    muldiv_pkg::word_t src_a, src_b, alu_out;

    thi_sel_t   thi_sel;
    tlo_sel_t   tlo_sel;
    src_a_sel_t src_a_sel;
    src_b_sel_t src_b_sel;
    cin_sel_t   cin_sel;

    logic a_is_neg, b_is_neg;
    logic a_abs_iter, div_take;
    logic cin, cout, cout_reg;
    logic neg_src_b, tick_run;
    logic a_neg_we, b_neg_we;

    assign a_is_neg = using_sign & a[N-1];
    assign b_is_neg = using_sign & b[N-1];
    assign a_abs    = a_is_neg ? a_neg : a;
    assign b_abs    = b_is_neg ? b_neg : b;

    // multiply walks a from bit 0 up, divide from the msb down (31 - t is ~t)
    assign a_abs_iter = a_abs[mul ? tick_count : ~tick_count];

    // remainder msb set means the shifted value already exceeds the divisor
    assign div_take = cout | thi[N-1];

    assign hi_out = thi;
    assign lo_out = tlo;

    // the one adder, subtraction by inverting src_b and forcing carry in
    assign {cout, alu_out} = {1'b0, src_a} + {1'b0, src_b} + {{N{1'b0}}, cin};

    always_comb begin
        case (src_a_sel)
            SRCA_THI:       src_a = thi;
            SRCA_THI_SHIFT: src_a = {thi[N-2:0], a_abs_iter};
            SRCA_HI:        src_a = hi_in;
            SRCA_LO:        src_a = lo_in;
            default:        src_a = '0;
        endcase

        case (src_b_sel)
            SRCB_THI:     src_b = thi;
            SRCB_A:       src_b = a;
            SRCB_B:       src_b = b;
            SRCB_ABS_B:   src_b = b_abs;
            SRCB_AITER_B: src_b = b_abs & {N{a_abs_iter}};
            default:      src_b = tlo;
        endcase
        if (neg_src_b) begin
            src_b = ~src_b;
        end

        case (cin_sel)
            CIN_ONE:  cin = 1'b1;
            CIN_COUT: cin = cout_reg;
            default:  cin = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        cout_reg <= cout;
        if (a_neg_we) begin
            a_neg <= alu_out;
        end
        if (b_neg_we) begin
            b_neg <= alu_out;
        end

        case (thi_sel)
            THI_ALU:  thi <= alu_out;
            THI_MUL:  thi <= {cout, alu_out[N-1:1]};
            THI_DIV:  thi <= div_take ? alu_out : src_a;
            THI_ZERO: thi <= '0;
            default:  thi <= thi;
        endcase

        case (tlo_sel)
            TLO_ALU: tlo <= alu_out;
            // product bits leave the adder lsb and enter tlo from the top
            TLO_MUL: tlo <= {alu_out[0], tlo[N-1:1]};
            TLO_DIV: tlo <= {tlo[N-2:0], div_take};
            default: tlo <= tlo;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= muldiv_pkg::WAIT;
            tick_count <= '0;
        end else begin
            state      <= clear ? muldiv_pkg::WAIT : next_state;
            tick_count <= tick_run ? tick_count + 1'b1 : '0;
        end
    end

    // state after the operands are made positive, and after the product is ready
    assign op_state  = mul ? muldiv_pkg::MUL : muldiv_pkg::DIV;
    assign acc_state = add ? muldiv_pkg::ADD_TLO :
                       sub ? muldiv_pkg::SUB_TLO : muldiv_pkg::STORAGE;

    always_comb begin
        next_state = state;
        case (state)
            muldiv_pkg::WAIT: begin
                if (mul | div) begin
                    if (a_is_neg)
                        next_state = muldiv_pkg::MAKE_ABS_A;
                    else if (b_is_neg)
                        next_state = muldiv_pkg::MAKE_ABS_B;
                    else
                        next_state = op_state;
                end
            end
            muldiv_pkg::MAKE_ABS_A:
                next_state = b_is_neg ? muldiv_pkg::MAKE_ABS_B : op_state;
            muldiv_pkg::MAKE_ABS_B:
                next_state = op_state;
            muldiv_pkg::MUL: begin
                if (&tick_count)
                    next_state = (a_is_neg ^ b_is_neg) ? muldiv_pkg::NEG_PRODUCT_TLO : acc_state;
            end
            muldiv_pkg::DIV: begin
                // quotient follows a xor b, remainder follows a
                if (&tick_count) begin
                    if (a_is_neg ^ b_is_neg)
                        next_state = muldiv_pkg::NEG_QUOTIENT_TLO;
                    else if (a_is_neg)
                        next_state = muldiv_pkg::NEG_REMAINDER_THI;
                    else
                        next_state = muldiv_pkg::STORAGE;
                end
            end
            muldiv_pkg::NEG_PRODUCT_TLO:
                next_state = muldiv_pkg::NEG_PRODUCT_THI;
            muldiv_pkg::NEG_PRODUCT_THI:
                next_state = acc_state;
            muldiv_pkg::NEG_QUOTIENT_TLO:
                next_state = a_is_neg ? muldiv_pkg::NEG_REMAINDER_THI : muldiv_pkg::STORAGE;
            muldiv_pkg::SUB_TLO:
                next_state = muldiv_pkg::SUB_THI;
            muldiv_pkg::ADD_TLO:
                next_state = muldiv_pkg::ADD_THI;
            muldiv_pkg::STORAGE:
                next_state = muldiv_pkg::WAIT;
            default:
                next_state = muldiv_pkg::STORAGE;
        endcase
    end

    always_comb begin
        thi_sel     = THI_HOLD;
        tlo_sel     = TLO_HOLD;
        src_a_sel   = SRCA_ZERO;
        src_b_sel   = SRCB_TLO;
        cin_sel     = CIN_ZERO;
        neg_src_b   = 1'b0;
        tick_run    = 1'b0;
        a_neg_we    = 1'b0;
        b_neg_we    = 1'b0;
        write_hi_lo = 1'b0;
        case (state)
            // thi is kept at zero so MUL or DIV can start straight from here
            muldiv_pkg::WAIT:
                thi_sel = THI_ZERO;
            muldiv_pkg::MAKE_ABS_A: begin
                thi_sel   = THI_ZERO;
                src_b_sel = SRCB_A;
                neg_src_b = 1'b1;
                cin_sel   = CIN_ONE;
                a_neg_we  = 1'b1;
            end
            muldiv_pkg::MAKE_ABS_B: begin
                thi_sel   = THI_ZERO;
                src_b_sel = SRCB_B;
                neg_src_b = 1'b1;
                cin_sel   = CIN_ONE;
                b_neg_we  = 1'b1;
            end
            muldiv_pkg::MUL: begin
                thi_sel   = THI_MUL;
                tlo_sel   = TLO_MUL;
                src_a_sel = SRCA_THI;
                src_b_sel = SRCB_AITER_B;
                tick_run  = 1'b1;
            end
            muldiv_pkg::DIV: begin
                thi_sel   = THI_DIV;
                tlo_sel   = TLO_DIV;
                src_a_sel = SRCA_THI_SHIFT;
                src_b_sel = SRCB_ABS_B;
                neg_src_b = 1'b1;
                cin_sel   = CIN_ONE;
                tick_run  = 1'b1;
            end
            muldiv_pkg::NEG_PRODUCT_TLO, muldiv_pkg::NEG_QUOTIENT_TLO: begin
                tlo_sel   = TLO_ALU;
                neg_src_b = 1'b1;
                cin_sel   = CIN_ONE;
            end
            muldiv_pkg::NEG_PRODUCT_THI, muldiv_pkg::NEG_REMAINDER_THI: begin
                // the product's upper half takes the borrow of the lower half
                thi_sel   = THI_ALU;
                src_b_sel = SRCB_THI;
                neg_src_b = 1'b1;
                cin_sel   = (state == muldiv_pkg::NEG_PRODUCT_THI) ? CIN_COUT : CIN_ONE;
            end
            muldiv_pkg::SUB_TLO, muldiv_pkg::ADD_TLO: begin
                tlo_sel   = TLO_ALU;
                src_a_sel = SRCA_LO;
                neg_src_b = (state == muldiv_pkg::SUB_TLO);
                cin_sel   = (state == muldiv_pkg::SUB_TLO) ? CIN_ONE : CIN_ZERO;
            end
            muldiv_pkg::SUB_THI, muldiv_pkg::ADD_THI: begin
                thi_sel   = THI_ALU;
                src_a_sel = SRCA_HI;
                src_b_sel = SRCB_THI;
                neg_src_b = (state == muldiv_pkg::SUB_THI);
                cin_sel   = CIN_COUT;
            end
            muldiv_pkg::STORAGE:
                write_hi_lo = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/hilo_file.sv */
// HI/LO registers loaded from the engine result or from direct bus writes
`timescale 1ns/100ps
`default_nettype none

module hilo_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              write_hi_lo,
    input  muldiv_pkg::word_t hi_result,
    input  muldiv_pkg::word_t lo_result,
    input  logic              bus_hi_we,
    input  logic              bus_lo_we,
    input  muldiv_pkg::word_t bus_dat,
    output muldiv_pkg::word_t hi,
    output muldiv_pkg::word_t lo
);

    // bus writes are held off while busy, the engine result still wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (write_hi_lo) begin
            hi <= hi_result;
            lo <= lo_result;
        end else begin
            if (bus_hi_we) begin
                hi <= bus_dat;
            end
            if (bus_lo_we) begin
                lo <= bus_dat;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/muldiv_wb_slave.sv */
// wishbone classic slave with operand and command registers, busy interlock and read mux
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_wb_slave (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  muldiv_pkg::reg_adr_t wb_adr,
    input  muldiv_pkg::word_t    wb_dat_w,
    output muldiv_pkg::word_t    wb_dat_r,
    output logic                 wb_ack,
    input  logic                 write_hi_lo,
    input  muldiv_pkg::word_t    hi,
    input  muldiv_pkg::word_t    lo,
    output logic                 mul,
    output logic                 div,
    output logic                 using_sign,
    output logic                 add,
    output logic                 sub,
    output logic                 clear,
    output muldiv_pkg::word_t    a,
    output muldiv_pkg::word_t    b,
    output logic                 bus_hi_we,
    output logic                 bus_lo_we
);

    muldiv_pkg::word_t opa, opb, rd_data;
    logic busy;
    logic req, status_rd, cmd_wr, abort_wr, do_access;

    // the ack cycle masks the request that caused it
    assign req       = wb_cyc & wb_stb & ~wb_ack;
    assign status_rd = ~wb_we & (wb_adr == `REG_STATUS);
    assign cmd_wr    = wb_we & (wb_adr == `REG_CMD);
    assign abort_wr  = cmd_wr & wb_dat_w[`CMD_ABORT_BIT];

    // everything but a status poll or an abort waits for the engine
    assign do_access = req & (~busy | status_rd | abort_wr);

    assign clear     = do_access & abort_wr;
    assign bus_hi_we = do_access & wb_we & (wb_adr == `REG_HI);
    assign bus_lo_we = do_access & wb_we & (wb_adr == `REG_LO);
    assign a         = opa;
    assign b         = opb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack     <= 1'b0;
            busy       <= 1'b0;
            mul        <= 1'b0;
            div        <= 1'b0;
            using_sign <= 1'b0;
            add        <= 1'b0;
            sub        <= 1'b0;
        end else begin
            wb_ack <= do_access;
            if (clear || write_hi_lo) begin
                busy <= 1'b0;
                mul  <= 1'b0;
                div  <= 1'b0;
            end else if (do_access && cmd_wr) begin
                mul        <= wb_dat_w[`CMD_MUL_BIT];
                div        <= wb_dat_w[`CMD_DIV_BIT];
                using_sign <= wb_dat_w[`CMD_SIGNED_BIT];
                add        <= wb_dat_w[`CMD_ADD_BIT];
                sub        <= wb_dat_w[`CMD_SUB_BIT];
                // a command without an operation never starts the engine
                busy       <= wb_dat_w[`CMD_MUL_BIT] | wb_dat_w[`CMD_DIV_BIT];
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `REG_OPA: rd_data = opa;
            `REG_OPB: rd_data = opb;
            `REG_CMD: begin
                rd_data[`CMD_MUL_BIT]    = mul;
                rd_data[`CMD_DIV_BIT]    = div;
                rd_data[`CMD_SIGNED_BIT] = using_sign;
                rd_data[`CMD_ADD_BIT]    = add;
                rd_data[`CMD_SUB_BIT]    = sub;
            end
            `REG_STATUS: rd_data[0] = busy;
            `REG_HI: rd_data = hi;
            `REG_LO: rd_data = lo;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_access && wb_we && wb_adr == `REG_OPA) begin
            opa <= wb_dat_w;
        end
        if (do_access && wb_we && wb_adr == `REG_OPB) begin
            opb <= wb_dat_w;
        end
        // read data is captured with the ack and valid while it is high
        if (do_access && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/muldiv_top.sv */
// multiply/divide coprocessor top joining the bus slave, the engine and the HI/LO registers
`timescale 1ns/100ps
`default_nettype none

module muldiv_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  muldiv_pkg::reg_adr_t wb_adr,
    input  muldiv_pkg::word_t    wb_dat_w,
    output muldiv_pkg::word_t    wb_dat_r,
    output logic                 wb_ack
);

    muldiv_pkg::word_t a, b, hi, lo, hi_out, lo_out;
    logic mul, div, using_sign, add, sub, clear;
    logic write_hi_lo, bus_hi_we, bus_lo_we;

    muldiv_wb_slave slave_i (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .write_hi_lo (write_hi_lo),
        .hi          (hi),
        .lo          (lo),
        .mul         (mul),
        .div         (div),
        .using_sign  (using_sign),
        .add         (add),
        .sub         (sub),
        .clear       (clear),
        .a           (a),
        .b           (b),
        .bus_hi_we   (bus_hi_we),
        .bus_lo_we   (bus_lo_we)
    );

    muldiv_core core_i (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .mul         (mul),
        .div         (div),
        .using_sign  (using_sign),
        .add         (add),
        .sub         (sub),
        .a           (a),
        .b           (b),
        .hi_in       (hi),
        .lo_in       (lo),
        .hi_out      (hi_out),
        .lo_out      (lo_out),
        .write_hi_lo (write_hi_lo)
    );

    // direct HI/LO writes take their data straight from the bus
    hilo_file hilo_i (
        .clk         (clk),
        .reset       (reset),
        .write_hi_lo (write_hi_lo),
        .hi_result   (hi_out),
        .lo_result   (lo_out),
        .bus_hi_we   (bus_hi_we),
        .bus_lo_we   (bus_lo_we),
        .bus_dat     (wb_dat_w),
        .hi          (hi),
        .lo          (lo)
    );

endmodule

`default_nettype wire

/* verification/muldiv_asserts.sv */
// bound checks on the wishbone ack and on the engine completion
`timescale 1ns/100ps
`default_nettype none

module muldiv_asserts (
    input logic                      clk,
    input logic                      reset,
    input logic                      wb_ack,
    input logic                      write_hi_lo,
    input logic                      clear,
    input muldiv_pkg::engine_state_t state
);

    // cycles spent outside WAIT since the engine last left it
    logic [7:0] run_cycles;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_cycles <= '0;
        end else if (state == muldiv_pkg::WAIT || clear) begin
            run_cycles <= '0;
        end else begin
            run_cycles <= run_cycles + 8'd1;
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else $error("wb_ack stayed high for two cycles");

    store_pulse: assert property (@(posedge clk) disable iff (reset)
        write_hi_lo |=> !write_hi_lo)
        else $error("write_hi_lo lasted more than one cycle");

    engine_done: assert property (@(posedge clk) disable iff (reset) run_cycles <= 8'd40)
        else $error("engine stayed out of WAIT for more than 40 cycles");

endmodule

bind muldiv_top muldiv_asserts asserts_i (
    .clk         (clk),
    .reset       (reset),
    .wb_ack      (wb_ack),
    .write_hi_lo (write_hi_lo),
    .clear       (clear),
    .state       (core_i.state)
);

`default_nettype wire

/* verification/muldiv_tb.sv */
// testbench for the multiply/divide coprocessor, replays bus patterns and checks HI/LO
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_tb;

    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int ROW_WORDS      = 7;
    localparam int MAX_ROWS       = 32;

    logic                 clk;
    logic                 reset;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic                 wb_ack;
    muldiv_pkg::reg_adr_t wb_adr;
    muldiv_pkg::word_t    wb_dat_w;
    muldiv_pkg::word_t    wb_dat_r;

    // command, opa, opb, initial hi, initial lo, expected hi, expected lo
    muldiv_pkg::word_t patterns [0:ROW_WORDS*MAX_ROWS-1];
    logic [31:0] lfsr;
    int checks;
    int errors;
    int timeouts;

    muldiv_top muldiv_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    task automatic check_value(input string name, input muldiv_pkg::word_t actual,
                               input muldiv_pkg::word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // one classic cycle, entered and left 2 ns after a rising edge
    task automatic wb_cycle(input logic we, input muldiv_pkg::reg_adr_t adr,
                            input muldiv_pkg::word_t wdata,
                            output muldiv_pkg::word_t rdata, output int waited);
        int cycles;
        logic acked;
        cycles = 0;
        acked  = 1'b0;
        rdata  = '0;
        if (timeouts == 0) begin
            wb_cyc   = 1'b1;
            wb_stb   = 1'b1;
            wb_we    = we;
            wb_adr   = adr;
            wb_dat_w = wdata;
            while (!acked && cycles < TIMEOUT_CYCLES) begin
                @(posedge clk);
                #DRIVE_DELAY;
                cycles++;
                if (wb_ack) begin
                    acked = 1'b1;
                    rdata = wb_dat_r;
                end
            end
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            if (!acked) begin
                $display("timeout: no ack within %0d cycles for register %0d", cycles, adr);
                timeouts++;
            end
        end
        waited = cycles;
    endtask

    task automatic write_reg(input muldiv_pkg::reg_adr_t adr, input muldiv_pkg::word_t data);
        muldiv_pkg::word_t unused;
        int waited;
        wb_cycle(1'b1, adr, data, unused, waited);
    endtask

    task automatic read_reg(input muldiv_pkg::reg_adr_t adr, output muldiv_pkg::word_t data);
        int waited;
        wb_cycle(1'b0, adr, '0, data, waited);
    endtask

    // lfsr picks whether an idle cycle goes between two transfers
    task automatic maybe_idle();
        logic gap;
        gap  = lfsr[0];
        lfsr = galois_step(lfsr);
        if (gap) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic poll_idle();
        muldiv_pkg::word_t status;
        int waited;
        int cycles;
        cycles = 0;
        status = 32'h1;
        while (status[0] && cycles < TIMEOUT_CYCLES && timeouts == 0) begin
            wb_cycle(1'b0, `REG_STATUS, '0, status, waited);
            cycles += waited;
        end
        if (status[0] && timeouts == 0) begin
            $display("timeout: busy still set after %0d cycles of polling", cycles);
            timeouts++;
        end
    endtask

    task automatic replay_pattern(input int row);
        muldiv_pkg::word_t hi_val;
        muldiv_pkg::word_t lo_val;
        int base;
        base = row * ROW_WORDS;
        write_reg(`REG_HI, patterns[base + 3]);
        maybe_idle();
        write_reg(`REG_LO, patterns[base + 4]);
        maybe_idle();
        write_reg(`REG_OPA, patterns[base + 1]);
        maybe_idle();
        write_reg(`REG_OPB, patterns[base + 2]);
        maybe_idle();
        write_reg(`REG_CMD, patterns[base]);
        poll_idle();
        read_reg(`REG_HI, hi_val);
        maybe_idle();
        read_reg(`REG_LO, lo_val);
        check_value($sformatf("row %0d HI", row), hi_val, patterns[base + 5]);
        check_value($sformatf("row %0d LO", row), lo_val, patterns[base + 6]);
    endtask

    // HI read straight after the command is held until the product is stored
    task automatic run_interlock();
        muldiv_pkg::word_t data;
        int waited;
        write_reg(`REG_OPA, 32'h87654321);
        write_reg(`REG_OPB, 32'h00000100);
        write_reg(`REG_CMD, 32'h1 << `CMD_MUL_BIT);
        wb_cycle(1'b0, `REG_HI, '0, data, waited);
        check_value("interlocked HI", data, 32'h00000087);
        if (timeouts == 0 && waited < 32) begin
            errors++;
            $display("HI read during a multiply was acked after only %0d cycles", waited);
        end
        read_reg(`REG_LO, data);
        check_value("interlocked LO", data, 32'h65432100);
    endtask

    task automatic run_abort();
        muldiv_pkg::word_t data;
        write_reg(`REG_HI, 32'h0badf00d);
        write_reg(`REG_LO, 32'h600dcafe);
        write_reg(`REG_OPA, 32'h7fffffff);
        write_reg(`REG_OPB, 32'h00000003);
        write_reg(`REG_CMD, 32'h1 << `CMD_DIV_BIT);
        maybe_idle();
        write_reg(`REG_CMD, 32'h1 << `CMD_ABORT_BIT);
        read_reg(`REG_STATUS, data);
        check_value("STATUS after abort", data, 32'h0);
        // long enough for the divide to have finished had it kept running
        repeat (50) @(posedge clk);
        #DRIVE_DELAY;
        read_reg(`REG_HI, data);
        check_value("HI after abort", data, 32'h0badf00d);
        read_reg(`REG_LO, data);
        check_value("LO after abort", data, 32'h600dcafe);
    endtask

    initial begin
        muldiv_pkg::word_t data;
        int idx;
        int row;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        reset    = 1'b1;
        lfsr     = 32'h30a1;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        for (idx = 0; idx < ROW_WORDS * MAX_ROWS; idx++) begin
            patterns[idx] = '0;
        end
        $readmemh("verification/muldiv_patterns.hex", patterns);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        read_reg(`REG_HI, data);
        check_value("HI after reset", data, '0);
        read_reg(`REG_LO, data);
        check_value("LO after reset", data, '0);
        read_reg(`REG_STATUS, data);
        check_value("STATUS after reset", data, '0);

        write_reg(`REG_OPA, 32'ha5a55a5a);
        maybe_idle();
        write_reg(`REG_OPB, 32'h0123fedc);
        read_reg(`REG_OPA, data);
        check_value("OPA", data, 32'ha5a55a5a);
        read_reg(`REG_OPB, data);
        check_value("OPB", data, 32'h0123fedc);

        // a zero command word ends the table
        row = 0;
        while (row < MAX_ROWS && patterns[row * ROW_WORDS] != 0) begin
            replay_pattern(row);
            row++;
        end
        if (row == 0) begin
            errors++;
            $display("no pattern rows were loaded from the data file");
        end

        run_interlock();
        run_abort();

        $display("checks %0d, errors %0d, timeouts %0d, rows %0d",
                 checks, errors, timeouts, row);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/muldiv_patterns.hex */
// columns: command, operand A, operand B, initial HI, initial LO, expected HI, expected LO
// command bits: 1 mul, 2 div, 4 signed, 8 add, 10 sub
00000005 00000007 00000006 12345678 9abcdef0 00000000 0000002a
00000005 fffffff9 00000006 00000000 00000000 ffffffff ffffffd6
00000005 00000007 fffffffa 00000000 00000000 ffffffff ffffffd6
00000005 fffffff9 fffffffa 00000000 00000000 00000000 0000002a
00000005 80000000 80000000 00000000 00000000 40000000 00000000
00000005 12345678 ffff0000 00000000 00000000 ffffedcb a9880000
00000001 ffffffff ffffffff 00000000 00000000 fffffffe 00000001
00000001 80000000 00000003 00000000 00000000 00000001 80000000
00000002 00000064 00000007 00000000 00000000 00000002 0000000e
00000006 ffffff9c 00000007 00000000 00000000 fffffffe fffffff2
00000006 00000064 fffffff9 00000000 00000000 00000002 fffffff2
00000006 ffffff9c fffffff9 00000000 00000000 fffffffe 0000000e
00000006 ffffffd6 00000006 00000000 00000000 00000000 fffffff9
00000002 ffffffff 00000010 00000000 00000000 0000000f 0fffffff
00000002 fffffff9 00000007 00000000 00000000 00000004 24924923
00000002 fffffffe 80000001 00000000 00000000 7ffffffd 00000001
00000009 00000002 00000003 00000000 ffffffff 00000001 00000005
0000000d fffffffe 00000009 00000000 00000010 ffffffff fffffffe
0000000d 00000001 00000001 7fffffff ffffffff 80000000 00000000
00000011 00000001 00000001 00000001 00000000 00000000 ffffffff
00000015 fffffffd 00000004 00000000 00000005 00000000 00000011
00000015 00000002 00000003 00000000 00000004 ffffffff fffffffe

/* build.f */
+incdir+include
hdl/muldiv_pkg.sv
hdl/muldiv_core.sv
hdl/hilo_file.sv
hdl/muldiv_wb_slave.sv
hdl/muldiv_top.sv
verification/muldiv_asserts.sv
verification/muldiv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the multiply/divide testbench with Verilator, run it and scan the log

set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f build.f --top-module muldiv_tb -o muldiv_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/muldiv_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Verification failed" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

exit 0
